//--- design/vga_text_pkg.sv
`default_nettype none

package vga_text_pkg;

	// one byte off the ps2 wire
	typedef logic [7:0] ps2_byte_t;

	// 0 blank, 1..10 digits 0-9, 11..16 A-F
	typedef logic [4:0] char_code_t;

	// row * TEXT_COLS + column
	typedef logic [12:0] text_addr_t;

	typedef logic [9:0] h_count_t;
	typedef logic [9:0] v_count_t;

	// msb is the leftmost pixel
	typedef logic [7:0] glyph_row_t;

	typedef logic [7:0] color_t;

	typedef enum logic [1:0] {
		IDLE,
		BREAK,
		WRITE
	} key_state_t;

	// 640x480 at 60 Hz, pixel clock is the system clock
	localparam int H_ACTIVE     = 640;
	localparam int H_SYNC_START = 656;
	localparam int H_SYNC_END   = 752;
	localparam int H_TOTAL      = 800;

	localparam int V_ACTIVE     = 480;
	localparam int V_SYNC_START = 490;
	localparam int V_SYNC_END   = 492;
	localparam int V_TOTAL      = 525;

	// 8x8 cells
	localparam int TEXT_COLS   = 80;
	localparam int TEXT_ROWS   = 60;
	localparam int TEXT_CELLS  = TEXT_COLS * TEXT_ROWS;
	localparam int GLYPH_COUNT = 17;

	// scan position to pixel out
	localparam int RENDER_LATENCY = 2;

	localparam color_t FG_LEVEL = 8'hFF;
	localparam color_t BG_LEVEL = 8'h00;

	localparam ps2_byte_t BREAK_PREFIX = 8'hF0;

endpackage

`default_nettype wire

//--- design/ps2_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module ps2_receiver (
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire                      ps2_clk,
	input  wire                      ps2_data,
	output vga_text_pkg::ps2_byte_t  ps2_byte,
	output logic                     ps2_strobe
);
	import vga_text_pkg::*;

	logic [2:0]  clk_sync;
	logic [2:0]  data_sync;
	logic        clk_prev;
	logic        clk_fall;
	logic [10:0] frame;
	logic [3:0]  bit_cnt;
	logic        frame_done;
	logic        frame_good;

	// device drives data on the rising edge, so sample on falling
	assign clk_fall = clk_prev & ~clk_sync[2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			clk_sync <= 3'b111;
			clk_prev <= 1'b1;
		end else begin
			clk_sync <= {clk_sync[1:0], ps2_clk};
			clk_prev <= clk_sync[2];
		end
	end

	always_ff @(posedge clk) begin
		data_sync <= {data_sync[1:0], ps2_data};
	end

	// lsb first, start bit ends up in frame[0]
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_cnt    <= '0;
			frame_done <= 1'b0;
		end else begin
			frame_done <= 1'b0;
			if (clk_fall) begin
				if (bit_cnt == 4'd10) begin
					bit_cnt    <= '0;
					frame_done <= 1'b1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (clk_fall)
			frame <= {data_sync[2], frame[10:1]};
	end

	// start low, odd parity over data+parity, stop high
	assign frame_good = ~frame[0] & (^frame[9:1]) & frame[10];

	always_ff @(posedge clk) begin
		if (!rst_n)
			ps2_strobe <= 1'b0;
		else
			ps2_strobe <= frame_done & frame_good;
	end

	always_ff @(posedge clk) begin
		if (frame_done && frame_good)
			ps2_byte <= frame[8:1];
	end

endmodule

`default_nettype wire

//--- design/key_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module key_decoder (
	input  wire                        clk,
	input  wire                        rst_n,
	input  wire vga_text_pkg::ps2_byte_t ps2_byte,
	input  wire                        ps2_strobe,
	input  wire                        wr_grant,
	output logic                       wr_req,
	output vga_text_pkg::text_addr_t   wr_addr,
	output vga_text_pkg::char_code_t   wr_char
);
	import vga_text_pkg::*;

	key_state_t state;
	logic       map_hit;
	char_code_t map_char;

	// set 2 make codes only
	always_comb begin
		map_hit  = 1'b1;
		map_char = char_code_t'(0);
		case (ps2_byte)
			8'h45: map_char = char_code_t'(1);
			8'h16: map_char = char_code_t'(2);
			8'h1E: map_char = char_code_t'(3);
			8'h26: map_char = char_code_t'(4);
			8'h25: map_char = char_code_t'(5);
			8'h2E: map_char = char_code_t'(6);
			8'h36: map_char = char_code_t'(7);
			8'h3D: map_char = char_code_t'(8);
			8'h3E: map_char = char_code_t'(9);
			8'h46: map_char = char_code_t'(10);
			8'h1C: map_char = char_code_t'(11);
			8'h32: map_char = char_code_t'(12);
			8'h21: map_char = char_code_t'(13);
			8'h23: map_char = char_code_t'(14);
			8'h24: map_char = char_code_t'(15);
			8'h2B: map_char = char_code_t'(16);
			// space
			8'h29: map_char = char_code_t'(0);
			default: map_hit = 1'b0;
		endcase
	end

	assign wr_req = (state == WRITE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state   <= IDLE;
			wr_addr <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (ps2_strobe) begin
						if (ps2_byte == BREAK_PREFIX)
							state <= BREAK;
						else if (map_hit)
							state <= WRITE;
					end
				end
				// released key code, drop it
				BREAK: begin
					if (ps2_strobe)
						state <= IDLE;
				end
				WRITE: begin
					if (wr_grant) begin
						state <= IDLE;
						if (wr_addr == text_addr_t'(TEXT_CELLS - 1))
							wr_addr <= '0;
						else
							wr_addr <= wr_addr + text_addr_t'(1);
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && ps2_strobe && map_hit && ps2_byte != BREAK_PREFIX)
			wr_char <= map_char;
	end

endmodule

`default_nettype wire

//--- design/text_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module text_arbiter (
	input  wire                          clk,
	input  wire                          rd_req,
	input  wire vga_text_pkg::text_addr_t rd_addr,
	input  wire                          wr_req,
	input  wire vga_text_pkg::text_addr_t wr_addr,
	input  wire vga_text_pkg::char_code_t wr_char,
	output vga_text_pkg::char_code_t     rd_char,
	output logic                         wr_grant
);
	import vga_text_pkg::*;

	char_code_t mem [TEXT_CELLS];
	text_addr_t port_addr;

	initial begin
		for (int i = 0; i < TEXT_CELLS; i++)
			mem[i] = char_code_t'(0);
	end

	// renderer always wins the port
	assign wr_grant  = wr_req & ~rd_req;
	assign port_addr = rd_req ? rd_addr : wr_addr;

	always_ff @(posedge clk) begin
		if (wr_grant)
			mem[port_addr] <= wr_char;
		if (rd_req)
			rd_char <= mem[port_addr];
	end

endmodule

`default_nettype wire

//--- design/vga_timing.sv
`timescale 1ns/10ps
`default_nettype none

module vga_timing (
	input  wire                     clk,
	input  wire                     rst_n,
	output vga_text_pkg::h_count_t  h_count,
	output vga_text_pkg::v_count_t  v_count,
	output logic                    active,
	output logic                    hsync_raw,
	output logic                    vsync_raw
);
	import vga_text_pkg::*;

	h_count_t h_next;
	v_count_t v_next;

	always_comb begin
		h_next = h_count + h_count_t'(1);
		v_next = v_count;
		if (h_count == h_count_t'(H_TOTAL - 1)) begin
			h_next = '0;
			if (v_count == v_count_t'(V_TOTAL - 1))
				v_next = '0;
			else
				v_next = v_count + v_count_t'(1);
		end
	end

	// flags follow the next position so they line up with the counters
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			h_count   <= '0;
			v_count   <= '0;
			// 0,0 is the first visible pixel
			active    <= 1'b1;
			hsync_raw <= 1'b1;
			vsync_raw <= 1'b1;
		end else begin
			h_count   <= h_next;
			v_count   <= v_next;
			active    <= (h_next < H_ACTIVE) && (v_next < V_ACTIVE);
			hsync_raw <= !((h_next >= H_SYNC_START) && (h_next < H_SYNC_END));
			vsync_raw <= !((v_next >= V_SYNC_START) && (v_next < V_SYNC_END));
		end
	end

endmodule

`default_nettype wire

//--- design/glyph_renderer.sv
`timescale 1ns/10ps
`default_nettype none

module glyph_renderer (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire vga_text_pkg::h_count_t  h_count,
	input  wire vga_text_pkg::v_count_t  v_count,
	input  wire                          active,
	input  wire                          hsync_raw,
	input  wire                          vsync_raw,
	input  wire vga_text_pkg::char_code_t rd_char,
	output logic                         rd_req,
	output vga_text_pkg::text_addr_t     rd_addr,
	output logic                         hsync,
	output logic                         vsync,
	output logic                         blank_n,
	output vga_text_pkg::color_t         vga_r,
	output vga_text_pkg::color_t         vga_g,
	output vga_text_pkg::color_t         vga_b
);
	import vga_text_pkg::*;

	logic [63:0] font_rom [GLYPH_COUNT];
	logic [63:0] glyph_word;
	logic        fetch_d1;
	logic [2:0]  row_d1;
	logic [2:0]  col_d1;
	logic [2:0]  col_d2;
	logic        active_d1;
	logic        hsync_d1;
	logic        vsync_d1;
	glyph_row_t  glyph_row;
	logic        pixel_on;
	color_t      level;

	// glyph row 0 sits in bits 63:56
	initial begin
		$readmemh("design/font.hex", font_rom);
	end

	// one fetch per 8-pixel cell
	assign rd_req  = active && (h_count[2:0] == 3'd0);
	assign rd_addr = text_addr_t'(v_count[9:3]) * text_addr_t'(TEXT_COLS)
		+ text_addr_t'(h_count[9:3]);

	assign glyph_word = (rd_char < GLYPH_COUNT) ? font_rom[rd_char] : '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_d1  <= 1'b0;
			active_d1 <= 1'b0;
			blank_n   <= 1'b0;
			hsync_d1  <= 1'b1;
			hsync     <= 1'b1;
			vsync_d1  <= 1'b1;
			vsync     <= 1'b1;
		end else begin
			fetch_d1  <= rd_req;
			active_d1 <= active;
			blank_n   <= active_d1;
			hsync_d1  <= hsync_raw;
			hsync     <= hsync_d1;
			vsync_d1  <= vsync_raw;
			vsync     <= vsync_d1;
		end
	end

	always_ff @(posedge clk) begin
		row_d1 <= v_count[2:0];
		col_d1 <= h_count[2:0];
		col_d2 <= col_d1;
		// rd_char is valid the cycle after rd_req
		if (fetch_d1)
			glyph_row <= glyph_word[{3'd7 - row_d1, 3'b000} +: 8];
	end

	assign pixel_on = glyph_row[3'd7 - col_d2];
	assign level    = pixel_on ? FG_LEVEL : BG_LEVEL;

	// outside the active area all channels are 0
	assign vga_r = blank_n ? level : '0;
	assign vga_g = blank_n ? level : '0;
	assign vga_b = blank_n ? level : '0;

endmodule

`default_nettype wire

//--- design/vga_text_top.sv
`timescale 1ns/10ps
`default_nettype none

module vga_text_top (
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire                          ps2_clk,
	input  wire                          ps2_data,
	output wire                          hsync,
	output wire                          vsync,
	output wire                          blank_n,
	output wire vga_text_pkg::color_t    vga_r,
	output wire vga_text_pkg::color_t    vga_g,
	output wire vga_text_pkg::color_t    vga_b,
	output wire vga_text_pkg::ps2_byte_t key_code,
	output wire                          key_valid
);
	import vga_text_pkg::*;

	logic       wr_req;
	logic       wr_grant;
	text_addr_t wr_addr;
	char_code_t wr_char;
	logic       rd_req;
	text_addr_t rd_addr;
	char_code_t rd_char;
	h_count_t   h_count;
	v_count_t   v_count;
	logic       active;
	logic       hsync_raw;
	logic       vsync_raw;

	ps2_receiver u_ps2_receiver (
		.clk        (clk),
		.rst_n      (rst_n),
		.ps2_clk    (ps2_clk),
		.ps2_data   (ps2_data),
		.ps2_byte   (key_code),
		.ps2_strobe (key_valid)
	);

	key_decoder u_key_decoder (
		.clk        (clk),
		.rst_n      (rst_n),
		.ps2_byte   (key_code),
		.ps2_strobe (key_valid),
		.wr_grant   (wr_grant),
		.wr_req     (wr_req),
		.wr_addr    (wr_addr),
		.wr_char    (wr_char)
	);

	text_arbiter u_text_arbiter (
		.clk      (clk),
		.rd_req   (rd_req),
		.rd_addr  (rd_addr),
		.wr_req   (wr_req),
		.wr_addr  (wr_addr),
		.wr_char  (wr_char),
		.rd_char  (rd_char),
		.wr_grant (wr_grant)
	);

	vga_timing u_vga_timing (
		.clk       (clk),
		.rst_n     (rst_n),
		.h_count   (h_count),
		.v_count   (v_count),
		.active    (active),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw)
	);

	glyph_renderer u_glyph_renderer (
		.clk       (clk),
		.rst_n     (rst_n),
		.h_count   (h_count),
		.v_count   (v_count),
		.active    (active),
		.hsync_raw (hsync_raw),
		.vsync_raw (vsync_raw),
		.rd_char   (rd_char),
		.rd_req    (rd_req),
		.rd_addr   (rd_addr),
		.hsync     (hsync),
		.vsync     (vsync),
		.blank_n   (blank_n),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b)
	);

endmodule

`default_nettype wire

//--- tb/tb_clock.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
	output logic clk
);
	localparam int HALF_PERIOD_NS = 10;

	// 20 ns period, first rising edge at 10 ns
	initial begin
		clk = 1'b0;
		forever begin
			#(HALF_PERIOD_NS);
			clk = ~clk;
		end
	end

endmodule

`default_nettype wire

//--- tb/tb_vga_text.sv
`timescale 1ns/10ps
`default_nettype none

module tb_vga_text;
	import vga_text_pkg::*;

	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 2;
	localparam int SEED         = 30;
	localparam int PS2_HALF     = 20;
	localparam int KEY_WAIT     = 30;
	localparam int FRAME_GAP    = 40;
	localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
	localparam int KEY_CYCLES   = 1000;
	// about 60 keys plus two frames with margin
	localparam int TIMEOUT_CYCLES = (60 * KEY_CYCLES + 2 * FRAME_CYCLES) * 5 / 3;

	wire       clk;
	logic      rst_n;
	logic      ps2_clk;
	logic      ps2_data;
	logic      hsync;
	logic      vsync;
	logic      blank_n;
	color_t    vga_r;
	color_t    vga_g;
	color_t    vga_b;
	ps2_byte_t key_code;
	logic      key_valid;

	int          error_count   = 0;
	int          tests_run     = 0;
	int          tests_failed  = 0;
	int          key_count     = 0;
	int          scan_n        = 0;
	int          cycle_count   = 0;
	int          cursor        = 0;
	logic        break_pending = 1'b0;
	logic        sync_check_on = 1'b0;
	ps2_byte_t   last_key;
	char_code_t  model_buf [TEXT_CELLS];
	logic [63:0] font_model [GLYPH_COUNT];

	tb_clock u_tb_clock (
		.clk (clk)
	);

	vga_text_top u_vga_text_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.ps2_clk   (ps2_clk),
		.ps2_data  (ps2_data),
		.hsync     (hsync),
		.vsync     (vsync),
		.blank_n   (blank_n),
		.vga_r     (vga_r),
		.vga_g     (vga_g),
		.vga_b     (vga_b),
		.key_code  (key_code),
		.key_valid (key_valid)
	);

	// scan index that the timing block shows
	always @(posedge clk) begin
		if (!rst_n)
			scan_n <= 0;
		else
			scan_n <= scan_n + 1;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run stopped after %0d cycles", cycle_count);
			$display("Done: errors found");
			$finish;
		end
	end

	function automatic int char_of_scan(input ps2_byte_t code);
		case (code)
			8'h45: return 1;
			8'h16: return 2;
			8'h1E: return 3;
			8'h26: return 4;
			8'h25: return 5;
			8'h2E: return 6;
			8'h36: return 7;
			8'h3D: return 8;
			8'h3E: return 9;
			8'h46: return 10;
			8'h1C: return 11;
			8'h32: return 12;
			8'h21: return 13;
			8'h23: return 14;
			8'h24: return 15;
			8'h2B: return 16;
			8'h29: return 0;
			default: return -1;
		endcase
	endfunction

	function automatic ps2_byte_t random_mapped_code();
		ps2_byte_t code;
		code = ps2_byte_t'($urandom % 256);
		while (char_of_scan(code) < 0)
			code = ps2_byte_t'($urandom % 256);
		return code;
	endfunction

	function automatic ps2_byte_t random_unmapped_code();
		ps2_byte_t code;
		code = ps2_byte_t'($urandom % 256);
		while (char_of_scan(code) >= 0 || code == BREAK_PREFIX)
			code = ps2_byte_t'($urandom % 256);
		return code;
	endfunction

	// outputs at cycle n show scan position n - RENDER_LATENCY
	function automatic void predict_outputs(input int n, output logic exp_h,
		output logic exp_v, output logic exp_bn, output color_t exp_lvl);
		int p;
		int h;
		int v;
		logic [63:0] word;
		exp_h   = 1'b1;
		exp_v   = 1'b1;
		exp_bn  = 1'b0;
		exp_lvl = '0;
		if (n >= RENDER_LATENCY) begin
			p = (n - RENDER_LATENCY) % FRAME_CYCLES;
			h = p % H_TOTAL;
			v = p / H_TOTAL;
			exp_h = !(h >= H_SYNC_START && h < H_SYNC_END);
			exp_v = !(v >= V_SYNC_START && v < V_SYNC_END);
			if (h < H_ACTIVE && v < V_ACTIVE) begin
				exp_bn  = 1'b1;
				word    = font_model[model_buf[(v / 8) * TEXT_COLS + h / 8]];
				exp_lvl = word[63 - 8 * (v % 8) - (h % 8)] ? FG_LEVEL : BG_LEVEL;
			end
		end
	endfunction

	task automatic check_byte(input ps2_byte_t got, input ps2_byte_t exp);
		if (got !== exp) begin
			$display("ERROR %0t: key_code %h, expected %h", $time, got, exp);
			error_count++;
		end
	endtask

	task automatic check_pixel(input color_t got_r, input color_t got_g,
		input color_t got_b, input color_t exp_r, input color_t exp_g,
		input color_t exp_b, input int n);
		if (got_r !== exp_r || got_g !== exp_g || got_b !== exp_b) begin
			$display("ERROR %0t: pixel at cycle %0d is %h/%h/%h, expected %h/%h/%h",
				$time, n, got_r, got_g, got_b, exp_r, exp_g, exp_b);
			error_count++;
		end
	endtask

	task automatic check_sync(input logic got_h, input logic got_v, input logic got_bn,
		input logic exp_h, input logic exp_v, input logic exp_bn, input int n);
		if (got_h !== exp_h || got_v !== exp_v || got_bn !== exp_bn) begin
			$display("ERROR %0t: hsync/vsync/blank_n at cycle %0d are %b%b%b, expected %b%b%b",
				$time, n, got_h, got_v, got_bn, exp_h, exp_v, exp_bn);
			error_count++;
		end
	endtask

	always @(negedge clk) begin : monitor
		logic   exp_h;
		logic   exp_v;
		logic   exp_bn;
		color_t exp_lvl;
		if (key_valid === 1'b1) begin
			key_count++;
			last_key = key_code;
		end
		if (sync_check_on) begin
			predict_outputs(scan_n, exp_h, exp_v, exp_bn, exp_lvl);
			check_sync(hsync, vsync, blank_n, exp_h, exp_v, exp_bn, scan_n);
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (error_count == errs_before) begin
			$display("test %s: pass", name);
		end else begin
			tests_failed++;
			$display("test %s: FAIL with %0d errors", name, error_count - errs_before);
		end
	endtask

	task automatic check_reset_outputs(input int n);
		check_sync(hsync, vsync, blank_n, 1'b1, 1'b1, 1'b0, n);
		check_pixel(vga_r, vga_g, vga_b, '0, '0, '0, n);
		if (key_valid !== 1'b0) begin
			$display("ERROR %0t: key_valid at cycle %0d is %b, expected 0",
				$time, n, key_valid);
			error_count++;
		end
	endtask

	// start 0, data lsb first, odd parity, stop 1
	task automatic send_frame(input ps2_byte_t data, input logic bad_parity);
		logic [10:0] bits;
		logic        parity;
		parity = ~^data;
		if (bad_parity)
			parity = ~parity;
		bits = {1'b1, parity, data, 1'b0};
		for (int i = 0; i < 11; i++) begin
			ps2_data = bits[i];
			wait_cycles(PS2_HALF / 2);
			ps2_clk = 1'b0;
			wait_cycles(PS2_HALF);
			ps2_clk = 1'b1;
			wait_cycles(PS2_HALF / 2);
		end
		ps2_data = 1'b1;
	endtask

	task automatic model_key(input ps2_byte_t code);
		int ch;
		ch = char_of_scan(code);
		if (break_pending) begin
			break_pending = 1'b0;
		end else if (code == BREAK_PREFIX) begin
			break_pending = 1'b1;
		end else if (ch >= 0) begin
			model_buf[cursor] = char_code_t'(ch);
			cursor = (cursor + 1) % TEXT_CELLS;
		end
	endtask

	task automatic send_good_byte(input ps2_byte_t code);
		int count_before;
		int waited;
		count_before = key_count;
		waited = 0;
		send_frame(code, 1'b0);
		while (key_count == count_before && waited < KEY_WAIT) begin
			wait_cycles(1);
			waited++;
		end
		if (key_count == count_before) begin
			$display("no key_valid seen for a good frame carrying %h", code);
			error_count++;
		end else begin
			check_byte(last_key, code);
		end
		model_key(code);
		wait_cycles(FRAME_GAP);
		if (key_count > count_before + 1) begin
			$display("more than one key_valid for a frame carrying %h", code);
			error_count++;
		end
	endtask

	task automatic send_bad_byte(input ps2_byte_t code);
		int count_before;
		count_before = key_count;
		send_frame(code, 1'b1);
		wait_cycles(KEY_WAIT + FRAME_GAP);
		if (key_count != count_before) begin
			$display("key_valid pulsed for a frame with bad parity carrying %h", code);
			error_count++;
		end
	endtask

	initial begin
		int errs_before;
		int kind;
		rst_n    = 1'b0;
		ps2_clk  = 1'b1;
		ps2_data = 1'b1;
		void'($urandom(SEED));
		$readmemh("design/font.hex", font_model);
		for (int i = 0; i < TEXT_CELLS; i++)
			model_buf[i] = '0;

		errs_before = error_count;
		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge clk);
			#(DRIVE_DELAY);
			check_reset_outputs(i);
		end
		rst_n = 1'b1;
		// pipeline still holds reset values
		repeat (RENDER_LATENCY) begin
			@(negedge clk);
			check_reset_outputs(scan_n);
		end
		wait_cycles(1);
		sync_check_on = 1'b1;
		report_test("reset state", errs_before);

		errs_before = error_count;
		for (int i = 0; i < 40; i++)
			send_good_byte(ps2_byte_t'($urandom % 256));
		report_test("byte reception", errs_before);

		errs_before = error_count;
		for (int i = 0; i < 5; i++)
			send_bad_byte(ps2_byte_t'($urandom % 256));
		report_test("parity errors", errs_before);

		errs_before = error_count;
		for (int i = 0; i < 12; i++) begin
			kind = $urandom % 3;
			if (kind == 0) begin
				send_good_byte(random_mapped_code());
			end else if (kind == 1) begin
				send_good_byte(BREAK_PREFIX);
				send_good_byte(random_mapped_code());
			end else begin
				send_good_byte(random_unmapped_code());
			end
		end
		report_test("break and mapping", errs_before);

		errs_before = error_count;
		do
			@(negedge clk);
		while (scan_n < RENDER_LATENCY || (scan_n - RENDER_LATENCY) % FRAME_CYCLES != 0);
		for (int i = 0; i < FRAME_CYCLES; i++) begin
			logic   exp_h;
			logic   exp_v;
			logic   exp_bn;
			color_t exp_lvl;
			if (i > 0)
				@(negedge clk);
			predict_outputs(scan_n, exp_h, exp_v, exp_bn, exp_lvl);
			check_pixel(vga_r, vga_g, vga_b, exp_lvl, exp_lvl, exp_lvl, scan_n);
		end
		report_test("frame content", errs_before);

		$display("tests: %0d run, %0d failed, %0d error lines", tests_run, tests_failed,
			error_count);
		if (error_count == 0 && tests_failed == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- design/font.hex
// one 8x8 glyph per line, font row 0 in the top byte: blank, 0-9, A-F
0000000000000000
3C666E7666663C00
1838181818187E00
3C66060C30607E00
3C66061C06663C00
0C1C3C6C7E0C0C00
7E607C0606663C00
3C607C6666663C00
7E060C1830303000
3C66663C66663C00
3C66663E060C3800
183C66667E666600
7C66667C66667C00
3C66606060663C00
786C6666666C7800
7E60607C60607E00
7E60607C60606000

//--- verilog.f
design/vga_text_pkg.sv
design/ps2_receiver.sv
design/key_decoder.sv
design/text_arbiter.sv
design/vga_timing.sv
design/glyph_renderer.sv
design/vga_text_top.sv
tb/tb_clock.sv
tb/tb_vga_text.sv

//--- Bender.yml
package:
  name: vga_text

sources:
  - files:
      - design/vga_text_pkg.sv
      - design/ps2_receiver.sv
      - design/key_decoder.sv
      - design/text_arbiter.sv
      - design/vga_timing.sv
      - design/glyph_renderer.sv
      - design/vga_text_top.sv
  - target: simulation
    files:
      - tb/tb_clock.sv
      - tb/tb_vga_text.sv

# simulation top: tb_vga_text
# synthesis top: vga_text_top
# font.hex is read from design/ relative to the project root
